//--- bpPkg.sv
/*
 * Branch predictor package
 * Widths, table geometry, reset vector, instruction class encoding
 * and the control FSM states shared by the fetch-side predictor
 */

package bpPkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////
  localparam int Xlen         = 32;
  localparam int BtbIndexBits = 6;
  localparam int BtbEntries   = 2 ** BtbIndexBits;

  // First fetch address out of reset
  localparam logic [Xlen-1:0] ResetVector = 32'h0000_1000;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////
  typedef logic [Xlen-1:0]         addrT;
  typedef logic [BtbIndexBits-1:0] btbIndexT;
  // One-hot class, zero for plain instructions
  typedef logic [3:0]              instrClassT;
  // Class in the top four bits, target below
  typedef logic [Xlen+3:0]         btbEntryT;

  // Class encoding
  localparam instrClassT ClassNone    = 4'b0000;
  localparam instrClassT ClassBranch  = 4'b0001;
  localparam instrClassT ClassJump    = 4'b0010;
  localparam instrClassT ClassJumpReg = 4'b0100;
  localparam instrClassT ClassReturn  = 4'b1000;

  // Control FSM
  typedef enum logic {ClearTable, Run} bpStateT;

endpackage

//--- bpIfs.sv
/*
 * Predictor internal interfaces
 * btbUpdateIf carries table writes from control into the BTB,
 * fetchCtrlIf carries next-PC steering from control into the PC sequencer
 */

`timescale 1ns/1ps

// Table write port, one entry per valid cycle
interface btbUpdateIf;
  logic              valid;
  // PC of the resolved instruction, hashed inside the BTB
  bpPkg::addrT       pc;
  bpPkg::addrT       target;
  bpPkg::instrClassT instrClass;

  modport master (output valid, output pc, output target, output instrClass);
  modport slave  (input valid, input pc, input target, input instrClass);
endinterface

// Next fetch PC steering
interface fetchCtrlIf;
  // Fetch beat accepted this cycle
  logic        advance;
  // Mispredict redirect, overrides everything
  logic        redirect;
  bpPkg::addrT redirectPc;
  // Prediction for the current fetch PC
  logic        predTaken;
  bpPkg::addrT predTarget;

  modport master (
    output advance, output redirect, output redirectPc,
    output predTaken, output predTarget
  );
  modport slave (
    input advance, input redirect, input redirectPc,
    input predTaken, input predTarget
  );
endinterface

//--- btbTable.sv
/*
 * BTB storage
 * One read port and one write port over BtbEntries entries,
 * registered read, read-during-write returns the old entry
 */

`timescale 1ns/1ps

module btbTable (
  input  logic            clk,
  input  logic            readEn,
  input  bpPkg::btbIndexT readIndex,
  output bpPkg::btbEntryT readData,
  input  logic            writeEn,
  input  bpPkg::btbIndexT writeIndex,
  input  bpPkg::btbEntryT writeData
);

  // Entry array, contents defined by the clear walk
  bpPkg::btbEntryT mem [bpPkg::BtbEntries];

  // Read port
  // Output register holds while readEn is low
  always_ff @(posedge clk) begin
    if (readEn) begin
      readData <= mem[readIndex];
    end
  end

  // Write port
  // Same-edge read sees the previous contents
  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[writeIndex] <= writeData;
    end
  end

endmodule

//--- btb.sv
/*
 * Branch target buffer
 * Tagless table indexed by a hashed PC, predicts target and class
 * for the current fetch PC, forwards a same-cycle write over the table
 */

`timescale 1ns/1ps

module btb (
  input  logic              clk,
  input  logic              reset,
  input  bpPkg::addrT       pcNext,
  input  bpPkg::addrT       pcF,
  input  logic              stall,
  btbUpdateIf.slave         update,
  output bpPkg::addrT       predTarget,
  output bpPkg::instrClassT predClass
);

  bpPkg::btbIndexT readIndex;
  bpPkg::btbIndexT heldIndex;
  bpPkg::btbIndexT writeIndex;
  bpPkg::btbEntryT tableData;
  bpPkg::btbEntryT updateEntry;
  bpPkg::btbEntryT fwdEntry;
  logic            readEn;
  logic            bypassMatch;
  logic            fwdValid;

  // PC to index hash
  // Bit 1 folded into the top index bit
  function automatic bpPkg::btbIndexT hashIndex(bpPkg::addrT pc);
    return {pc[bpPkg::BtbIndexBits+1] ^ pc[1], pc[bpPkg::BtbIndexBits:2]};
  endfunction

  assign readIndex   = hashIndex(pcNext);
  assign heldIndex   = hashIndex(pcF);
  assign writeIndex  = hashIndex(update.pc);
  assign updateEntry = {update.instrClass, update.target};

  // Table is read during reset and on every fetch PC change
  assign readEn = ~stall | reset;

  //////////////////////////////////////////////////
  // Write bypass
  //////////////////////////////////////////////////

  // Compare against the index being read, or the held one when stalled
  assign bypassMatch = update.valid &
                       (readEn ? (writeIndex == readIndex) : (writeIndex == heldIndex));

  // Prediction reads as empty out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      fwdValid <= 1'b1;
      fwdEntry <= '0;
    end else if (bypassMatch) begin
      fwdValid <= 1'b1;
      fwdEntry <= updateEntry;
    end else if (readEn) begin
      // Fresh table read, forward no longer applies
      fwdValid <= 1'b0;
    end
  end

  // Forwarded entry wins over the stale table output
  assign {predClass, predTarget} = fwdValid ? fwdEntry : tableData;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  btbTable btbTable_inst (
    .clk        (clk),
    .readEn     (readEn),
    .readIndex  (readIndex),
    .readData   (tableData),
    .writeEn    (update.valid),
    .writeIndex (writeIndex),
    .writeData  (updateEntry)
  );

  // Table and forward path only ever hold legal classes
  assert property (@(posedge clk) disable iff (reset) $onehot0(predClass))
    else $error("btb: predicted class is not one-hot");

endmodule

//--- fetchPcGen.sv
/*
 * Fetch PC sequencer
 * Holds the fetch PC and picks the next one from redirect,
 * predicted target, sequential or hold
 */

`timescale 1ns/1ps

module fetchPcGen (
  input  logic        clk,
  input  logic        reset,
  fetchCtrlIf.slave   fetchCtrl,
  output bpPkg::addrT pcNext,
  output bpPkg::addrT pcF
);

  bpPkg::addrT pcSeq;

  // Sequential fetch, fixed 32-bit instructions
  assign pcSeq = pcF + bpPkg::addrT'(4);

  // Next PC priority
  // Reset vector drives the table index during reset
  always_comb begin
    if (reset) begin
      pcNext = bpPkg::ResetVector;
    end else if (fetchCtrl.redirect) begin
      pcNext = fetchCtrl.redirectPc;
    end else if (fetchCtrl.advance) begin
      pcNext = fetchCtrl.predTaken ? fetchCtrl.predTarget : pcSeq;
    end else begin
      // Back-pressure, hold
      pcNext = pcF;
    end
  end

  // Fetch PC register
  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= bpPkg::ResetVector;
    end else begin
      pcF <= pcNext;
    end
  end

  // Redirects and predicted targets must stay halfword aligned
  assert property (@(posedge clk) disable iff (reset) !pcF[0])
    else $error("fetchPcGen: odd fetch PC");

endmodule

//--- bpControl.sv
/*
 * Predictor control
 * Clears the table after reset, runs both handshakes, turns
 * resolutions into table writes and mispredicts into redirects
 */

`timescale 1ns/1ps

module bpControl (
  input  logic              clk,
  input  logic              reset,
  output logic              fetchValid,
  input  logic              fetchReady,
  input  logic              resolveValid,
  output logic              resolveReady,
  input  bpPkg::addrT       resolvePc,
  input  bpPkg::addrT       resolveTarget,
  input  bpPkg::instrClassT resolveClass,
  input  logic              resolveMispredict,
  input  bpPkg::addrT       resolveNextPc,
  input  bpPkg::instrClassT predClass,
  input  bpPkg::addrT       predTarget,
  btbUpdateIf.master        update,
  fetchCtrlIf.master        fetchCtrl
);

  bpPkg::bpStateT    state;
  bpPkg::bpStateT    stateNext;
  bpPkg::btbIndexT   clearCount;
  bpPkg::addrT       clearPc;
  logic              clearDone;
  logic              resolveAccept;
  logic              mispredictAccept;
  logic              updValid;
  bpPkg::addrT       updPc;
  bpPkg::addrT       updTarget;
  bpPkg::instrClassT updClass;

  //////////////////////////////////////////////////
  // Clear walk and FSM
  //////////////////////////////////////////////////
  assign clearDone = clearCount == bpPkg::btbIndexT'(bpPkg::BtbEntries - 1);

  always_comb begin
    stateNext = state;
    case (state)
      bpPkg::ClearTable: if (clearDone) stateNext = bpPkg::Run;
      bpPkg::Run:        stateNext = bpPkg::Run;
      default:           stateNext = bpPkg::ClearTable;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= bpPkg::ClearTable;
      clearCount <= '0;
    end else begin
      state <= stateNext;
      // One index per cycle
      if (state == bpPkg::ClearTable) clearCount <= clearCount + 1'b1;
    end
  end

  // Walking PC whose hash is the clear index
  always_comb begin
    clearPc = '0;
    clearPc[bpPkg::BtbIndexBits+1:2] = clearCount;
  end

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////
  assign resolveReady     = state == bpPkg::Run;
  assign resolveAccept    = resolveValid & resolveReady;
  assign mispredictAccept = resolveAccept & resolveMispredict;
  // No fetch beat while a redirect is taken
  assign fetchValid       = (state == bpPkg::Run) & ~mispredictAccept;

  // Accepted resolution is written one clock later
  always_ff @(posedge clk) begin
    if (reset) updValid <= 1'b0;
    else       updValid <= resolveAccept;
  end

  always_ff @(posedge clk) begin
    if (resolveAccept) begin
      updPc     <= resolvePc;
      updTarget <= resolveTarget;
      updClass  <= resolveClass;
    end
  end

  // Table write source
  always_comb begin
    if (state == bpPkg::ClearTable) begin
      update.valid      = 1'b1;
      update.pc         = clearPc;
      update.target     = '0;
      update.instrClass = bpPkg::ClassNone;
    end else begin
      update.valid      = updValid;
      update.pc         = updPc;
      update.target     = updTarget;
      update.instrClass = updClass;
    end
  end

  // PC steering
  assign fetchCtrl.advance    = fetchValid & fetchReady;
  assign fetchCtrl.redirect   = mispredictAccept;
  assign fetchCtrl.redirectPc = resolveNextPc;
  assign fetchCtrl.predTaken  = |predClass;
  assign fetchCtrl.predTarget = predTarget;

  // Pending resolution keeps its valid until taken
  assert property (@(posedge clk) disable iff (reset)
    (resolveValid && !resolveReady) |=> resolveValid)
    else $error("bpControl: resolve valid dropped before accept");

  // Resolution payload stays put while it waits
  assert property (@(posedge clk) disable iff (reset)
    (resolveValid && !resolveReady) |=>
      ($stable(resolvePc) && $stable(resolveTarget) && $stable(resolveClass) &&
       $stable(resolveMispredict) && $stable(resolveNextPc)))
    else $error("bpControl: resolve payload changed before accept");

endmodule

//--- branchPredictor.sv
/*
 * Fetch-side branch predictor top level
 * Control, PC sequencer and BTB joined to plain fetch and resolution ports
 */

`timescale 1ns/1ps

module branchPredictor (
  input  logic              clk,
  input  logic              reset,
  // Fetch side
  output logic              fetchValid,
  input  logic              fetchReady,
  output bpPkg::addrT       fetchPc,
  output bpPkg::addrT       fetchPredTarget,
  output bpPkg::instrClassT fetchPredClass,
  // Resolution side
  input  logic              resolveValid,
  output logic              resolveReady,
  input  bpPkg::addrT       resolvePc,
  input  bpPkg::addrT       resolveTarget,
  input  bpPkg::instrClassT resolveClass,
  input  logic              resolveMispredict,
  input  bpPkg::addrT       resolveNextPc
);

  btbUpdateIf  updateBus ();
  fetchCtrlIf  fetchCtrlBus ();
  bpPkg::addrT pcNext;
  logic        btbStall;

  // Table read only when the fetch PC moves
  assign btbStall = ~(fetchCtrlBus.advance | fetchCtrlBus.redirect);

  bpControl bpControl_inst (
    .clk               (clk),
    .reset             (reset),
    .fetchValid        (fetchValid),
    .fetchReady        (fetchReady),
    .resolveValid      (resolveValid),
    .resolveReady      (resolveReady),
    .resolvePc         (resolvePc),
    .resolveTarget     (resolveTarget),
    .resolveClass      (resolveClass),
    .resolveMispredict (resolveMispredict),
    .resolveNextPc     (resolveNextPc),
    .predClass         (fetchPredClass),
    .predTarget        (fetchPredTarget),
    .update            (updateBus.master),
    .fetchCtrl         (fetchCtrlBus.master)
  );

  fetchPcGen fetchPcGen_inst (
    .clk       (clk),
    .reset     (reset),
    .fetchCtrl (fetchCtrlBus.slave),
    .pcNext    (pcNext),
    .pcF       (fetchPc)
  );

  btb btb_inst (
    .clk        (clk),
    .reset      (reset),
    .pcNext     (pcNext),
    .pcF        (fetchPc),
    .stall      (btbStall),
    .update     (updateBus.slave),
    .predTarget (fetchPredTarget),
    .predClass  (fetchPredClass)
  );

endmodule

//--- tbBranchPredictor.sv
/*
 * Branch predictor testbench
 * Walks a table of fetch, resolve and stall rows through the DUT
 * and checks fetch PCs and predictions against a model of the BTB
 */

`timescale 1ns/1ps

module tbBranchPredictor;

  localparam int NumRows  = 24;
  localparam int MaxWait  = 32;
  localparam int MaxClear = 200;

  // Row kinds
  localparam logic [1:0] KindFetch   = 2'd0;
  localparam logic [1:0] KindResolve = 2'd1;
  localparam logic [1:0] KindStall   = 2'd2;

  // Fetch and stall rows hold the expected fetch PC in pc
  typedef struct packed {
    logic [1:0]        kind;
    logic [3:0]        test;
    bpPkg::addrT       pc;
    bpPkg::addrT       target;
    bpPkg::instrClassT cls;
    logic              mispredict;
    bpPkg::addrT       nextPc;
  } stimRowT;

  logic              clk;
  logic              reset;
  logic              fetchValid;
  logic              fetchReady;
  bpPkg::addrT       fetchPc;
  bpPkg::addrT       fetchPredTarget;
  bpPkg::instrClassT fetchPredClass;
  logic              resolveValid;
  logic              resolveReady;
  bpPkg::addrT       resolvePc;
  bpPkg::addrT       resolveTarget;
  bpPkg::instrClassT resolveClass;
  logic              resolveMispredict;
  bpPkg::addrT       resolveNextPc;

  stimRowT           rows [NumRows];
  // Model of the table contents
  bpPkg::addrT       modelTarget [bpPkg::BtbEntries];
  bpPkg::instrClassT modelClass [bpPkg::BtbEntries];
  logic [15:0]       lfsrState;
  int                checks;
  int                errors;
  int                testErrors;
  int                currentTest;
  int                clearCycles;
  logic              aborted;

  branchPredictor branchPredictor_inst (
    .clk               (clk),
    .reset             (reset),
    .fetchValid        (fetchValid),
    .fetchReady        (fetchReady),
    .fetchPc           (fetchPc),
    .fetchPredTarget   (fetchPredTarget),
    .fetchPredClass    (fetchPredClass),
    .resolveValid      (resolveValid),
    .resolveReady      (resolveReady),
    .resolvePc         (resolvePc),
    .resolveTarget     (resolveTarget),
    .resolveClass      (resolveClass),
    .resolveMispredict (resolveMispredict),
    .resolveNextPc     (resolveNextPc)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
  // One step per bit
  function automatic logic lfsrNextBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  // Index is PC bits 7:2 with the top bit flipped by PC bit 1
  function automatic bpPkg::btbIndexT tableIndex(bpPkg::addrT pc);
    bpPkg::btbIndexT idx;
    idx = pc[bpPkg::BtbIndexBits+1:2];
    idx[bpPkg::BtbIndexBits-1] = idx[bpPkg::BtbIndexBits-1] ^ pc[1];
    return idx;
  endfunction

  task automatic noteError();
    errors++;
    testErrors++;
  endtask

  task automatic checkAddr(string name, bpPkg::addrT got, bpPkg::addrT exp);
    checks++;
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      noteError();
    end
  endtask

  task automatic checkClass(string name, bpPkg::instrClassT got, bpPkg::instrClassT exp);
    checks++;
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      noteError();
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      noteError();
    end
  endtask

  // Prediction must equal the last write to the PC's index
  task automatic checkPrediction(bpPkg::addrT pc);
    checkAddr("fetchPredTarget", fetchPredTarget, modelTarget[tableIndex(pc)]);
    checkClass("fetchPredClass", fetchPredClass, modelClass[tableIndex(pc)]);
  endtask

  task automatic reportTest(int id);
    if (testErrors == 0) begin
      $display("Test %0d passed", id);
    end else begin
      $display("Test %0d failed with %0d errors", id, testErrors);
    end
    testErrors = 0;
  endtask

  task automatic setRow(int n, logic [1:0] kind, logic [3:0] test, bpPkg::addrT pc,
                        bpPkg::addrT target, bpPkg::instrClassT cls, logic mis,
                        bpPkg::addrT nextPc);
    rows[n] = {kind, test, pc, target, cls, mis, nextPc};
  endtask

  //////////////////////////////////////////////////
  // Row handlers
  //////////////////////////////////////////////////

  // One accepted beat with fetchReady gaps from the LFSR
  task automatic runFetch(stimRowT row);
    int   waits;
    logic accepted;
    waits    = 0;
    accepted = 1'b0;
    while (!accepted && waits < MaxWait) begin
      @(posedge clk);
      #1;
      resolveValid = 1'b0;
      fetchReady   = lfsrNextBit();
      #4;
      // Same PC and prediction on every held cycle
      checkBit("fetchValid", fetchValid, 1'b1);
      checkAddr("fetchPc", fetchPc, row.pc);
      checkPrediction(row.pc);
      accepted = fetchValid & fetchReady;
      waits++;
    end
    if (!accepted) begin
      $display("Timeout: fetch beat at 0x%h was never accepted", row.pc);
      noteError();
      aborted = 1'b1;
    end
  endtask

  // Single cycle with fetchReady low
  task automatic runStall(stimRowT row);
    @(posedge clk);
    #1;
    resolveValid = 1'b0;
    fetchReady   = 1'b0;
    #4;
    checkBit("fetchValid", fetchValid, 1'b1);
    checkAddr("fetchPc", fetchPc, row.pc);
    checkPrediction(row.pc);
  endtask

  // Accept cycle and then one held cycle while the entry is written
  task automatic runResolve(stimRowT row);
    int   waits;
    logic accepted;
    waits    = 0;
    accepted = 1'b0;
    while (!accepted && waits < MaxWait) begin
      @(posedge clk);
      #1;
      fetchReady        = 1'b0;
      resolveValid      = 1'b1;
      resolvePc         = row.pc;
      resolveTarget     = row.target;
      resolveClass      = row.cls;
      resolveMispredict = row.mispredict;
      resolveNextPc     = row.nextPc;
      #4;
      accepted = resolveReady;
      waits++;
    end
    if (!accepted) begin
      $display("Timeout: resolution for 0x%h was never accepted", row.pc);
      noteError();
      aborted = 1'b1;
    end else begin
      // Redirect cycle carries no fetch beat
      checkBit("fetchValid", fetchValid, !row.mispredict);
      modelTarget[tableIndex(row.pc)] = row.target;
      modelClass[tableIndex(row.pc)]  = row.cls;
      @(posedge clk);
      #1;
      resolveValid = 1'b0;
      #4;
      if (row.mispredict) begin
        checkAddr("fetchPc", fetchPc, row.nextPc);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////
  task automatic loadRows();
    // First beat and sequential stepping
    setRow(0,  KindFetch,   1, 32'h1000, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(1,  KindFetch,   2, 32'h1004, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(2,  KindFetch,   2, 32'h1008, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(3,  KindFetch,   2, 32'h100C, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(4,  KindFetch,   2, 32'h1010, 32'h0,    4'h0, 1'b0, 32'h0);
    // Branch is learned and taken and then removed
    setRow(5,  KindResolve, 3, 32'h1018, 32'h1100, 4'h1, 1'b0, 32'h0);
    setRow(6,  KindFetch,   3, 32'h1014, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(7,  KindFetch,   3, 32'h1018, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(8,  KindFetch,   3, 32'h1100, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(9,  KindResolve, 3, 32'h1018, 32'h0,    4'h0, 1'b1, 32'h1018);
    setRow(10, KindFetch,   3, 32'h1018, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(11, KindFetch,   3, 32'h101C, 32'h0,    4'h0, 1'b0, 32'h0);
    // Mispredict redirect
    setRow(12, KindResolve, 4, 32'h1020, 32'h1400, 4'h2, 1'b1, 32'h1400);
    setRow(13, KindFetch,   4, 32'h1400, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(14, KindFetch,   4, 32'h1404, 32'h0,    4'h0, 1'b0, 32'h0);
    // 0x1030 and 0x10B2 both hash to index 12
    setRow(15, KindResolve, 5, 32'h1030, 32'h1500, 4'h1, 1'b1, 32'h1030);
    setRow(16, KindResolve, 5, 32'h10B2, 32'h1600, 4'h4, 1'b0, 32'h0);
    setRow(17, KindFetch,   5, 32'h1030, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(18, KindFetch,   5, 32'h1600, 32'h0,    4'h0, 1'b0, 32'h0);
    // Update to the held index
    setRow(19, KindStall,   6, 32'h1604, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(20, KindResolve, 6, 32'h1604, 32'h1700, 4'h8, 1'b0, 32'h0);
    setRow(21, KindStall,   6, 32'h1604, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(22, KindFetch,   6, 32'h1604, 32'h0,    4'h0, 1'b0, 32'h0);
    setRow(23, KindFetch,   6, 32'h1700, 32'h0,    4'h0, 1'b0, 32'h0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    clk               = 1'b0;
    reset             = 1'b1;
    fetchReady        = 1'b0;
    resolveValid      = 1'b0;
    resolvePc         = '0;
    resolveTarget     = '0;
    resolveClass      = '0;
    resolveMispredict = 1'b0;
    resolveNextPc     = '0;
    lfsrState         = 16'd99;
    checks            = 0;
    errors            = 0;
    testErrors        = 0;
    currentTest       = 1;
    aborted           = 1'b0;
    for (int i = 0; i < bpPkg::BtbEntries; i++) begin
      modelTarget[i] = '0;
      modelClass[i]  = '0;
    end
    loadRows();

    // Both handshakes idle while in reset
    repeat (4) begin
      @(posedge clk);
      #1;
      checkBit("fetchValid", fetchValid, 1'b0);
      checkBit("resolveReady", resolveReady, 1'b0);
      checkAddr("fetchPc", fetchPc, bpPkg::ResetVector);
    end
    reset = 1'b0;

    // Count the table clear cycles
    clearCycles = 0;
    #4;
    while (!fetchValid && clearCycles < MaxClear) begin
      checkBit("resolveReady", resolveReady, 1'b0);
      clearCycles++;
      @(posedge clk);
      #5;
    end
    checks++;
    if (clearCycles >= MaxClear) begin
      $display("Timeout: fetchValid never rose after reset");
      noteError();
      aborted = 1'b1;
    end else if (clearCycles != bpPkg::BtbEntries) begin
      $display("** Error: fetchValid low cycles = 0x%h, expected 0x%h",
               clearCycles, bpPkg::BtbEntries);
      noteError();
    end
    checkBit("resolveReady", resolveReady, 1'b1);

    for (int i = 0; i < NumRows; i++) begin
      if (!aborted) begin
        if (rows[i].test != currentTest) begin
          reportTest(currentTest);
          currentTest = rows[i].test;
        end
        case (rows[i].kind)
          KindFetch:   runFetch(rows[i]);
          KindResolve: runResolve(rows[i]);
          default:     runStall(rows[i]);
        endcase
      end
    end
    reportTest(currentTest);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
bpPkg.sv
bpIfs.sv
btbTable.sv
btb.sv
fetchPcGen.sv
bpControl.sv
branchPredictor.sv
tbBranchPredictor.sv

//--- Bender.yml
package:
  name: branch_predictor

sources:
  - bpPkg.sv
  - bpIfs.sv
  - btbTable.sv
  - btb.sv
  - fetchPcGen.sv
  - bpControl.sv
  - branchPredictor.sv
  - target: test
    files:
      - tbBranchPredictor.sv
